// ==== mul_defs.svh ====
// ---------------------------------------------------------------------
// width macros for the Booth multiplier
// MUL_WIDTH must be even and at least 8; the others derive from it
// ---------------------------------------------------------------------
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// operand width
`define MUL_WIDTH 16

// full double-width product
`define PROD_WIDTH (2 * `MUL_WIDTH)

// radix-4 digits, one extra to cover unsigned operands
`define NUM_PP (`MUL_WIDTH / 2 + 1)

// raw partial product spans -2m .. +2m
`define PP_WIDTH (`MUL_WIDTH + 2)

// tree inputs, power of two with room for the negate row
`define TREE_ROWS (1 << $clog2(`NUM_PP + 1))

`endif

// ==== mul_pkg.sv ====
// ---------------------------------------------------------------------
// vector types shared by the multiplier RTL and its testbench
// ---------------------------------------------------------------------
`include "mul_defs.svh"

package mul_pkg;

    // operands as they appear on the top level ports
    typedef logic [`MUL_WIDTH-1:0] operand_t;

    // full product
    typedef logic [`PROD_WIDTH-1:0] product_t;

    // one partial product before sign-extension compression
    typedef logic [`PP_WIDTH-1:0] pp_t;

    // booth digit select, bit 2 negate, bit 1 one, bit 0 two
    typedef logic [2:0] booth_sel_t;

    // aligned row inside the reduction tree
    typedef logic [`PROD_WIDTH-1:0] row_t;

endpackage

// ==== booth_if.sv ====
// ---------------------------------------------------------------------
// buses between recoder, partial product rows and reduction tree
// pp_bus_if valid is driven from the top level, not from the rows
// ---------------------------------------------------------------------
`include "mul_defs.svh"

// registered operands and decoded digits, one driver, many readers
interface booth_sel_if
    import mul_pkg::*;
();
    operand_t   multiplicand;
    logic       signed_mode;
    booth_sel_t digit [`NUM_PP];
    logic       valid;

    modport source (output multiplicand, signed_mode, digit, valid);
    modport sink (input multiplicand, signed_mode, digit, valid);
endinterface

// aligned partial products, each row owns one slot
interface pp_bus_if
    import mul_pkg::*;
();
    row_t rows [`NUM_PP];
    logic neg [`NUM_PP];
    logic valid;

    modport row (output rows, neg);
    modport sink (input rows, neg, valid);
endinterface

// ==== booth_recoder.sv ====
// ---------------------------------------------------------------------
// input register stage plus radix-4 Booth digit decode
// digit decode is combinational from the registered multiplier
// ---------------------------------------------------------------------
`include "mul_defs.svh"

module booth_recoder
    import mul_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        in_valid,
    input logic        signed_mode,
    input operand_t    multiplicand,
    input operand_t    multiplier,
    booth_sel_if.source sel
);

    operand_t mcand_q;
    operand_t mplier_q;
    logic     mode_q;
    logic     valid_q;
    logic     ext_bit;
    // two extension bits on top, implicit zero below bit 0
    logic [`MUL_WIDTH+2:0] mplier_ext;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        mcand_q  <= multiplicand;
        mplier_q <= multiplier;
        mode_q   <= signed_mode;
    end

    assign ext_bit    = mode_q & mplier_q[`MUL_WIDTH-1];
    assign mplier_ext = {ext_bit, ext_bit, mplier_q, 1'b0};

    // overlapping groups b[2i+1], b[2i], b[2i-1]
    for (genvar i = 0; i < `NUM_PP; i++)
    begin : g_digit
        logic [2:0] grp;

        assign grp = mplier_ext[2*i+2 -: 3];
        assign sel.digit[i][2] = grp[2];
        assign sel.digit[i][1] = grp[1] ^ grp[0];
        assign sel.digit[i][0] = (grp[2] & ~grp[1] & ~grp[0]) | (~grp[2] & grp[1] & grp[0]);
    end

    assign sel.multiplicand = mcand_q;
    assign sel.signed_mode  = mode_q;
    assign sel.valid        = valid_q;

endmodule

// ==== booth_pp_row.sv ====
// ---------------------------------------------------------------------
// one Booth partial product, sign-compressed and aligned by 2*ROW
// the +1 of a negated row travels separately on the neg bit
// ---------------------------------------------------------------------
`include "mul_defs.svh"

module booth_pp_row
    import mul_pkg::*;
#(
    parameter int ROW = 0
)
(
    booth_sel_if.sink sel,
    pp_bus_if.row     pp
);

    booth_sel_t            digit;
    logic [`MUL_WIDTH:0]   mcand_ext;
    pp_t                   pp_mag;
    pp_t                   pp_raw;
    logic                  sgn;
    logic [`PP_WIDTH+1:0]  pp_ext;

    assign digit = sel.digit[ROW];

    // one extra top bit so unsigned operands stay positive
    assign mcand_ext = {sel.signed_mode & sel.multiplicand[`MUL_WIDTH-1], sel.multiplicand};

    // select zero, m or 2m
    always_comb
    begin
        if (digit[1])
        begin
            pp_mag = {mcand_ext[`MUL_WIDTH], mcand_ext};
        end
        else if (digit[0])
        begin
            pp_mag = {mcand_ext, 1'b0};
        end
        else
        begin
            pp_mag = '0;
        end
    end

    // ones complement here, neg bit completes it in the tree
    assign pp_raw = digit[2] ? ~pp_mag : pp_mag;
    assign sgn    = pp_raw[`PP_WIDTH-1];

    // ---------------------------------------------------------------
    // sign extension prefix
    // ---------------------------------------------------------------
    if (ROW == 0)
    begin : g_first
        assign pp_ext = {~sgn, sgn, pp_raw};
    end
    else
    begin : g_rest
        assign pp_ext = {1'b0, 1'b1, ~sgn, pp_raw[`PP_WIDTH-2:0]};
    end

    assign pp.rows[ROW] = row_t'(pp_ext) << (2 * ROW);
    assign pp.neg[ROW]  = digit[2];

endmodule

// ==== compressor_42.sv ====
// ---------------------------------------------------------------------
// row-wide 4:2 compressor, sum + carry equals x1+x2+x3+x4 mod 2^W
// the bit that falls off the top of each carry row is dropped
// ---------------------------------------------------------------------
module compressor_42
    import mul_pkg::*;
(
    input  row_t x1,
    input  row_t x2,
    input  row_t x3,
    input  row_t x4,
    output row_t sum,
    output row_t carry
);

    row_t s1;
    row_t c1;
    row_t cin;
    row_t c2;

    // first full adder layer on x1..x3
    assign s1 = x1 ^ x2 ^ x3;
    assign c1 = (x1 & x2) | (x1 & x3) | (x2 & x3);

    // horizontal carry into the next column, no ripple
    assign cin = c1 << 1;

    // second layer folds in x4 and the horizontal carry
    assign sum = s1 ^ x4 ^ cin;
    assign c2  = (s1 & x4) | (s1 & cin) | (x4 & cin);

    assign carry = c2 << 1;

endmodule

// ==== pp_reduce_tree.sv ====
// ---------------------------------------------------------------------
// 4:2 reduction of the aligned rows, final add and product register
// rows are padded with zeros up to TREE_ROWS; product has no reset
// ---------------------------------------------------------------------
`include "mul_defs.svh"

module pp_reduce_tree
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    pp_bus_if.sink   pp,
    output product_t product,
    output logic     out_valid
);

    localparam int T      = `TREE_ROWS;
    localparam int LEVELS = $clog2(T) - 1;
    // every level stored back to back, level L starts at 2*(T - T>>L)
    localparam int NODES  = 2 * T - 2;

    row_t     node [NODES];
    row_t     neg_row;
    product_t sum_d;

    // negate bits of all rows share one extra row
    always_comb
    begin
        neg_row = '0;
        for (int i = 0; i < `NUM_PP; i++)
        begin
            neg_row[2*i] = pp.neg[i];
        end
    end

    // ---------------------------------------------------------------
    // level 0 inputs
    // ---------------------------------------------------------------
    for (genvar r = 0; r < T; r++)
    begin : g_input
        if (r < `NUM_PP)
        begin : g_pp
            assign node[r] = pp.rows[r];
        end
        else if (r == `NUM_PP)
        begin : g_neg
            assign node[r] = neg_row;
        end
        else
        begin : g_pad
            assign node[r] = '0;
        end
    end

    // ---------------------------------------------------------------
    // compressor levels, row count halves each time
    // ---------------------------------------------------------------
    for (genvar lvl = 0; lvl < LEVELS; lvl++)
    begin : g_level
        localparam int IN_OFF  = 2 * (T - (T >> lvl));
        localparam int OUT_OFF = 2 * (T - (T >> (lvl + 1)));

        for (genvar c = 0; c < (T >> lvl) / 4; c++)
        begin : g_comp
            compressor_42 u_comp (
                .x1    (node[IN_OFF + 4*c]),
                .x2    (node[IN_OFF + 4*c + 1]),
                .x3    (node[IN_OFF + 4*c + 2]),
                .x4    (node[IN_OFF + 4*c + 3]),
                .sum   (node[OUT_OFF + 2*c]),
                .carry (node[OUT_OFF + 2*c + 1])
            );
        end
    end

    // single carry-propagate add, overflow past PROD_WIDTH discarded
    assign sum_d = node[NODES-2] + node[NODES-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= pp.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        product <= sum_d;
    end

endmodule

// ==== booth_mul_top.sv ====
// ---------------------------------------------------------------------
// radix-4 Booth multiplier, two register stages, latency 2 clocks
// in_valid is sampled every cycle; there is no back-pressure
// ---------------------------------------------------------------------
`include "mul_defs.svh"

module booth_mul_top
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  logic     signed_mode,
    input  operand_t multiplicand,
    input  operand_t multiplier,
    output product_t product,
    output logic     out_valid
);

    booth_sel_if sel_bus ();
    pp_bus_if    pp_bus ();

    // stage 1: operand register and digit decode
    booth_recoder u_recoder (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .signed_mode  (signed_mode),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .sel          (sel_bus.source)
    );

    // partial product rows, one per booth digit
    for (genvar i = 0; i < `NUM_PP; i++)
    begin : g_row
        booth_pp_row #(
            .ROW (i)
        ) u_row (
            .sel (sel_bus.sink),
            .pp  (pp_bus.row)
        );
    end

    // valid skips the rows, they are pure logic
    assign pp_bus.valid = sel_bus.valid;

    // stage 2: reduction, final add, product register
    pp_reduce_tree u_tree (
        .clk       (clk),
        .reset     (reset),
        .pp        (pp_bus.sink),
        .product   (product),
        .out_valid (out_valid)
    );

endmodule

// ==== tb_booth_mul.sv ====
// ---------------------------------------------------------------------
// self-checking testbench for booth_mul_top, table plus random stimulus
// table expected values are written for the default 16-bit width
// ---------------------------------------------------------------------
`include "mul_defs.svh"

module tb_booth_mul
    import mul_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic     mode;
        operand_t a;
        operand_t b;
        product_t expect_p;
    } vec_t;

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     signed_mode;
    operand_t multiplicand;
    operand_t multiplier;
    product_t product;
    logic     out_valid;

    integer   seed = 32'h12a;
    int       cycle = 0;
    int       issued = 0;
    int       received = 0;
    string    phase = "reset";

    // scoreboard, one entry per accepted input
    product_t exp_prod [$];
    int       exp_cycle [$];
    string    exp_name [$];
    product_t pop_prod;
    string    pop_name;

    // first eight unsigned, last eight signed
    vec_t vectors [16] = '{
        '{1'b0, 16'h0000, 16'h0000, 32'h0000_0000},
        '{1'b0, 16'h0001, 16'h0001, 32'h0000_0001},
        '{1'b0, 16'hffff, 16'hffff, 32'hfffe_0001},
        '{1'b0, 16'haaaa, 16'h5555, 32'h38e3_1c72},
        '{1'b0, 16'haaaa, 16'haaaa, 32'h71c6_38e4},
        '{1'b0, 16'hffff, 16'h0001, 32'h0000_ffff},
        '{1'b0, 16'h8000, 16'h0002, 32'h0001_0000},
        '{1'b0, 16'h1234, 16'h5678, 32'h0626_0060},
        '{1'b1, 16'hffff, 16'hffff, 32'h0000_0001},
        '{1'b1, 16'h8000, 16'h8000, 32'h4000_0000},
        '{1'b1, 16'h8000, 16'hffff, 32'h0000_8000},
        '{1'b1, 16'h7fff, 16'h8000, 32'hc000_8000},
        '{1'b1, 16'h0003, 16'hfffb, 32'hffff_fff1},
        '{1'b1, 16'hfff9, 16'h0006, 32'hffff_ffd6},
        '{1'b1, 16'h7fff, 16'h7fff, 32'h3fff_0001},
        '{1'b1, 16'h0000, 16'h8000, 32'h0000_0000}
    };

    booth_mul_top uut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .signed_mode  (signed_mode),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .out_valid    (out_valid)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(string why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_product(string name, product_t expect_p, product_t actual);
        if (actual !== expect_p)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expect_p, actual);
            abort_run("product mismatch");
        end
    endtask

    task automatic check_valid(string name, logic expect_v, logic actual);
        if (actual !== expect_v)
        begin
            $display("[ERROR] %s: expected out_valid %b, actual %b", name, expect_v, actual);
            abort_run("out_valid mismatch");
        end
    endtask

    task automatic check_count(string name, int expect_n, int actual);
        if (actual != expect_n)
        begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expect_n, actual);
            abort_run("result count mismatch");
        end
    endtask

    // wide multiply on extended operands, kept modulo the product width
    function automatic product_t model_mul(logic mode, operand_t a, operand_t b);
        logic [`PROD_WIDTH-1:0]   ea;
        logic [`PROD_WIDTH-1:0]   eb;
        logic [2*`PROD_WIDTH-1:0] full;
        if (mode)
        begin
            ea = {{`MUL_WIDTH{a[`MUL_WIDTH-1]}}, a};
            eb = {{`MUL_WIDTH{b[`MUL_WIDTH-1]}}, b};
        end
        else
        begin
            ea = {{`MUL_WIDTH{1'b0}}, a};
            eb = {{`MUL_WIDTH{1'b0}}, b};
        end
        full = ea * eb;
        return full[`PROD_WIDTH-1:0];
    endfunction

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic issue(string name, logic mode, operand_t a, operand_t b, product_t expect_p);
        in_valid     = 1'b1;
        signed_mode  = mode;
        multiplicand = a;
        multiplier   = b;
        exp_prod.push_back(expect_p);
        exp_name.push_back(name);
        exp_cycle.push_back(cycle + 2);
        issued++;
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        in_valid     = 1'b0;
        multiplicand = operand_t'($random(seed));
        multiplier   = operand_t'($random(seed));
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_prod.size() > 0 && waited < 10)
        begin
            idle();
            waited++;
        end
        if (exp_prod.size() > 0)
        begin
            $display("timeout: %0d results never arrived on out_valid", exp_prod.size());
            abort_run("timeout while draining results");
        end
    endtask

    // ------------------------------------------------------------------
    // output monitor, samples at the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (cycle > 0)
        begin
            // every result the DUT flags counts
            if (out_valid === 1'b1)
            begin
                received++;
            end
            if (exp_cycle.size() > 0 && exp_cycle[0] == cycle)
            begin
                pop_prod = exp_prod.pop_front();
                pop_name = exp_name.pop_front();
                void'(exp_cycle.pop_front());
                check_valid(pop_name, 1'b1, out_valid);
                check_product(pop_name, pop_prod, product);
            end
            else
            begin
                check_valid(phase, 1'b0, out_valid);
            end
        end
    end

    initial
    begin
        operand_t a;
        operand_t b;
        logic     m;
        reset        = 1'b1;
        in_valid     = 1'b0;
        signed_mode  = 1'b0;
        multiplicand = '0;
        multiplier   = '0;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // nothing issued yet, out_valid must stay low
        phase = "idle after reset";
        repeat (4) idle();

        phase = "table";
        for (int i = 0; i < 16; i++)
        begin
            issue($sformatf("%s table %0d", vectors[i].mode ? "signed" : "unsigned", i),
                  vectors[i].mode, vectors[i].a, vectors[i].b, vectors[i].expect_p);
        end
        drain();

        // back to back with mode toggling each cycle
        phase = "toggle";
        for (int i = 0; i < 24; i++)
        begin
            m = 1'(i);
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            issue($sformatf("toggle %0d", i), m, a, b, model_mul(m, a, b));
        end
        drain();

        // random holes in in_valid
        phase = "gaps";
        for (int i = 0; i < 40; i++)
        begin
            if (1'($random(seed)))
            begin
                a = operand_t'($random(seed));
                b = operand_t'($random(seed));
                issue($sformatf("gap %0d", i), 1'b1, a, b, model_mul(1'b1, a, b));
            end
            else
            begin
                idle();
            end
        end
        drain();

        phase = "random";
        for (int i = 0; i < 300; i++)
        begin
            m = 1'($random(seed));
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            issue($sformatf("random %0d", i), m, a, b, model_mul(m, a, b));
        end
        drain();

        check_count("result count", issued, received);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
mul_pkg.sv
booth_if.sv
booth_recoder.sv
booth_pp_row.sv
compressor_42.sv
pp_reduce_tree.sv
booth_mul_top.sv
tb_booth_mul.sv

// ==== run.sh ====
#!/bin/sh
# build and run the Booth multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_booth_mul -o sim_booth_mul
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_booth_mul > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
